// File: src/conceal_cfg.svh
`ifndef CONCEAL_CFG_SVH
`define CONCEAL_CFG_SVH

// Frame geometry
`define FRAME_WIDTH 256
`define FRAME_LINES 240

// Data widths
`define PIXEL_W 8
`define FLAG_W 16

// Address widths, flag address is the line index
`define PIXEL_ADDR_W 16
`define LINE_W 8

`endif

// File: src/conceal_pkg.sv
`include "conceal_cfg.svh"

package conceal_pkg;

    typedef enum logic [1:0] {
        SIZE_16 = 2'd0,
        SIZE_32 = 2'd1,
        SIZE_64 = 2'd2
    } packet_size_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_CHECK,
        SEQ_CONCEAL,
        SEQ_FINISH
    } seq_state_e;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_READ,
        PORT_AVERAGE,
        PORT_WRITE
    } port_state_e;

    // Wishbone classic, pixel memory
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`PIXEL_ADDR_W-1:0] adr;
        logic [`PIXEL_W-1:0]      dat;
    } pix_wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [`PIXEL_W-1:0] dat;
    } pix_wb_rsp_t;

    // Wishbone classic, flag memory is read only
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic [`LINE_W-1:0] adr;
    } flag_wb_req_t;

    typedef struct packed {
        logic               ack;
        logic [`FLAG_W-1:0] dat;
    } flag_wb_rsp_t;

    typedef struct packed {
        logic at_top;
        logic at_bottom;
        logic at_left;
        logic at_right;
    } edge_flags_t;

    typedef struct packed {
        logic [`PIXEL_ADDR_W-1:0] adr;
        edge_flags_t              edges;
    } conceal_job_t;

    typedef struct packed {
        logic [`PIXEL_W-1:0] nw;
        logic [`PIXEL_W-1:0] n;
        logic [`PIXEL_W-1:0] ne;
        logic [`PIXEL_W-1:0] w;
        logic [`PIXEL_W-1:0] e;
        logic [`PIXEL_W-1:0] sw;
        logic [`PIXEL_W-1:0] s;
        logic [`PIXEL_W-1:0] se;
    } neighbours_t;

endpackage

// File: src/frame_sequencer.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module frame_sequencer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  conceal_pkg::packet_size_e size,
    output logic                      done,
    output conceal_pkg::flag_wb_req_t flag_req,
    input  conceal_pkg::flag_wb_rsp_t flag_rsp,
    output conceal_pkg::conceal_job_t job,
    output logic                      job_valid,
    input  logic                      job_done
);

    localparam int COL_W = $clog2(`FRAME_WIDTH);

    conceal_pkg::seq_state_e   state;
    conceal_pkg::packet_size_e size_q;
    logic [`FLAG_W-1:0]        flag_word;
    logic [`LINE_W-1:0]        line;
    logic [3:0]                packet;
    logic [5:0]                pixel;
    logic [3:0]                packet_last;
    logic [5:0]                pixel_last;
    logic [6:0]                pix_per_packet;
    logic [COL_W-1:0]          column;
    logic                      packet_flagged;
    logic                      advance;

    // Packet geometry from the size code latched at start
    always_comb begin
        case (size_q)
            conceal_pkg::SIZE_32: begin
                pix_per_packet = 7'd32;
                packet_last    = 4'd7;
            end
            conceal_pkg::SIZE_64: begin
                pix_per_packet = 7'd64;
                packet_last    = 4'd3;
            end
            default: begin
                pix_per_packet = 7'd16;
                packet_last    = 4'd15;
            end
        endcase
    end

    assign pixel_last = 6'(pix_per_packet - 7'd1);
    assign column = COL_W'(packet) * COL_W'(pix_per_packet) + COL_W'(pixel);

    // Bit 15 belongs to the leftmost packet
    assign packet_flagged = flag_word[`FLAG_W - 1 - packet];

    // Move on to the next packet, either a clear one or one fully concealed
    always_comb begin
        case (state)
            conceal_pkg::SEQ_CHECK:   advance = !packet_flagged;
            conceal_pkg::SEQ_CONCEAL: advance = job_done && (pixel == pixel_last);
            default:                  advance = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state     <= conceal_pkg::SEQ_IDLE;
            size_q    <= conceal_pkg::SIZE_16;
            line      <= '0;
            packet    <= '0;
            pixel     <= '0;
            job_valid <= 1'b0;
        end else begin
            case (state)
                conceal_pkg::SEQ_IDLE: begin
                    if (start) begin
                        size_q <= size;
                        line   <= '0;
                        packet <= '0;
                        pixel  <= '0;
                        state  <= conceal_pkg::SEQ_FETCH;
                    end
                end
                conceal_pkg::SEQ_FETCH: begin
                    if (flag_rsp.ack) begin
                        state <= conceal_pkg::SEQ_CHECK;
                    end
                end
                conceal_pkg::SEQ_CHECK: begin
                    if (packet_flagged) begin
                        job_valid <= 1'b1;
                        state     <= conceal_pkg::SEQ_CONCEAL;
                    end
                end
                conceal_pkg::SEQ_CONCEAL: begin
                    if (job_done) begin
                        job_valid <= 1'b0;
                        if (!advance) begin
                            pixel <= pixel + 6'd1;
                            state <= conceal_pkg::SEQ_CHECK;
                        end
                    end
                end
                default: begin
                    state <= conceal_pkg::SEQ_IDLE;
                end
            endcase

            if (advance) begin
                pixel <= '0;
                if (packet == packet_last) begin
                    packet <= '0;
                    if (line == `LINE_W'(`FRAME_LINES - 1)) begin
                        state <= conceal_pkg::SEQ_FINISH;
                    end else begin
                        line  <= line + 1'b1;
                        state <= conceal_pkg::SEQ_FETCH;
                    end
                end else begin
                    packet <= packet + 4'd1;
                    state  <= conceal_pkg::SEQ_CHECK;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == conceal_pkg::SEQ_FETCH && flag_rsp.ack) begin
            flag_word <= flag_rsp.dat;
        end
    end

    // Flag request held for the whole fetch state, dropped after ack
    assign flag_req.cyc = (state == conceal_pkg::SEQ_FETCH);
    assign flag_req.stb = (state == conceal_pkg::SEQ_FETCH);
    assign flag_req.adr = line;

    assign job.adr = `PIXEL_ADDR_W'(line) * `PIXEL_ADDR_W'(`FRAME_WIDTH)
                   + `PIXEL_ADDR_W'(column);
    assign job.edges.at_top    = (line == '0);
    assign job.edges.at_bottom = (line == `LINE_W'(`FRAME_LINES - 1));
    assign job.edges.at_left   = (column == '0);
    assign job.edges.at_right  = (column == COL_W'(`FRAME_WIDTH - 1));

    assign done = (state == conceal_pkg::SEQ_FINISH);

endmodule

// File: src/pixel_port.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module pixel_port (
    input  logic                      clock,
    input  logic                      reset,
    input  conceal_pkg::conceal_job_t job,
    input  logic                      job_valid,
    output logic                      job_done,
    output conceal_pkg::pix_wb_req_t  pix_req,
    input  conceal_pkg::pix_wb_rsp_t  pix_rsp,
    output conceal_pkg::neighbours_t  nbrs,
    output conceal_pkg::edge_flags_t  edges,
    output logic                      sum_start,
    input  logic [`PIXEL_W-1:0]       average,
    input  logic                      average_valid
);

    localparam logic [`PIXEL_ADDR_W-1:0] LINE_STEP = `PIXEL_ADDR_W'(`FRAME_WIDTH);

    conceal_pkg::port_state_e  state;
    conceal_pkg::conceal_job_t job_q;
    logic [7:0]                pending;
    logic [7:0]                pending_next;
    logic [2:0]                cur_idx;
    logic [`PIXEL_ADDR_W-1:0]  nbr_adr;
    logic                      cyc_q;
    logic                      accept;

    // Bit order nw, n, ne, w, e, sw, s, se from bit 0 up
    function automatic logic [7:0] present_mask(conceal_pkg::edge_flags_t e);
        logic [7:0] m;
        m[0] = !e.at_top && !e.at_left;
        m[1] = !e.at_top;
        m[2] = !e.at_top && !e.at_right;
        m[3] = !e.at_left;
        m[4] = !e.at_right;
        m[5] = !e.at_bottom && !e.at_left;
        m[6] = !e.at_bottom;
        m[7] = !e.at_bottom && !e.at_right;
        return m;
    endfunction

    // Lowest pending neighbour is read next
    always_comb begin
        cur_idx = 3'd0;
        for (int i = 7; i >= 0; i--) begin
            if (pending[i]) begin
                cur_idx = 3'(i);
            end
        end
    end

    assign pending_next = pending & ~(8'd1 << cur_idx);

    always_comb begin
        case (cur_idx)
            3'd0:    nbr_adr = job_q.adr - LINE_STEP - 1'b1;
            3'd1:    nbr_adr = job_q.adr - LINE_STEP;
            3'd2:    nbr_adr = job_q.adr - LINE_STEP + 1'b1;
            3'd3:    nbr_adr = job_q.adr - 1'b1;
            3'd4:    nbr_adr = job_q.adr + 1'b1;
            3'd5:    nbr_adr = job_q.adr + LINE_STEP - 1'b1;
            3'd6:    nbr_adr = job_q.adr + LINE_STEP;
            default: nbr_adr = job_q.adr + LINE_STEP + 1'b1;
        endcase
    end

    // job_valid is still high in the job_done cycle
    assign accept = (state == conceal_pkg::PORT_IDLE) && job_valid && !job_done;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state     <= conceal_pkg::PORT_IDLE;
            pending   <= '0;
            cyc_q     <= 1'b0;
            sum_start <= 1'b0;
            job_done  <= 1'b0;
        end else begin
            sum_start <= 1'b0;
            job_done  <= 1'b0;
            case (state)
                conceal_pkg::PORT_IDLE: begin
                    if (accept) begin
                        pending <= present_mask(job.edges);
                        cyc_q   <= 1'b1;
                        state   <= conceal_pkg::PORT_READ;
                    end
                end
                conceal_pkg::PORT_READ: begin
                    // One idle cycle between consecutive reads
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;
                    end else if (pix_rsp.ack) begin
                        cyc_q   <= 1'b0;
                        pending <= pending_next;
                        if (pending_next == '0) begin
                            sum_start <= 1'b1;
                            state     <= conceal_pkg::PORT_AVERAGE;
                        end
                    end
                end
                conceal_pkg::PORT_AVERAGE: begin
                    if (average_valid) begin
                        cyc_q <= 1'b1;
                        state <= conceal_pkg::PORT_WRITE;
                    end
                end
                default: begin
                    if (pix_rsp.ack) begin
                        cyc_q    <= 1'b0;
                        job_done <= 1'b1;
                        state    <= conceal_pkg::PORT_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            job_q <= job;
        end
        if (state == conceal_pkg::PORT_READ && cyc_q && pix_rsp.ack) begin
            case (cur_idx)
                3'd0:    nbrs.nw <= pix_rsp.dat;
                3'd1:    nbrs.n  <= pix_rsp.dat;
                3'd2:    nbrs.ne <= pix_rsp.dat;
                3'd3:    nbrs.w  <= pix_rsp.dat;
                3'd4:    nbrs.e  <= pix_rsp.dat;
                3'd5:    nbrs.sw <= pix_rsp.dat;
                3'd6:    nbrs.s  <= pix_rsp.dat;
                default: nbrs.se <= pix_rsp.dat;
            endcase
        end
    end

    assign edges = job_q.edges;

    // Averager holds its result until the next sum_start
    assign pix_req.cyc = cyc_q;
    assign pix_req.stb = cyc_q;
    assign pix_req.we  = cyc_q && (state == conceal_pkg::PORT_WRITE);
    assign pix_req.adr = (state == conceal_pkg::PORT_WRITE) ? job_q.adr : nbr_adr;
    assign pix_req.dat = average;

endmodule

// File: src/neighbour_average.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module neighbour_average (
    input  logic                     clock,
    input  logic                     reset,
    input  conceal_pkg::neighbours_t nbrs,
    input  conceal_pkg::edge_flags_t edges,
    input  logic                     sum_start,
    output logic [`PIXEL_W-1:0]      average,
    output logic                     average_valid
);

    localparam int SUM_W = `PIXEL_W + 3;

    logic [SUM_W-1:0] nw, n, ne, w, e, sw, s, se;
    logic [SUM_W-1:0] sum;

    assign nw = SUM_W'(nbrs.nw);
    assign n  = SUM_W'(nbrs.n);
    assign ne = SUM_W'(nbrs.ne);
    assign w  = SUM_W'(nbrs.w);
    assign e  = SUM_W'(nbrs.e);
    assign sw = SUM_W'(nbrs.sw);
    assign s  = SUM_W'(nbrs.s);
    assign se = SUM_W'(nbrs.se);

    // Missing neighbours replaced by doubling the nearest present ones
    always_comb begin
        case ({edges.at_top, edges.at_bottom, edges.at_left, edges.at_right})
            4'b1010: sum = 3 * e + 3 * s + 2 * se;
            4'b1001: sum = 3 * w + 3 * s + 2 * sw;
            4'b0110: sum = 3 * n + 3 * e + 2 * ne;
            4'b0101: sum = 3 * w + 3 * n + 2 * nw;
            4'b1000: sum = 2 * w + sw + 2 * s + se + 2 * e;
            4'b0100: sum = 2 * w + nw + 2 * n + ne + 2 * e;
            4'b0010: sum = 2 * n + ne + 2 * e + se + 2 * s;
            4'b0001: sum = 2 * n + nw + 2 * w + sw + 2 * s;
            default: sum = nw + n + ne + w + e + sw + s + se;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            average_valid <= 1'b0;
        end else begin
            average_valid <= sum_start;
        end
    end

    // Divide by eight
    always_ff @(posedge clock) begin
        if (sum_start) begin
            average <= sum[SUM_W-1:3];
        end
    end

endmodule

// File: src/concealment_top.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module concealment_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  conceal_pkg::packet_size_e size,
    output logic                      done,
    output conceal_pkg::pix_wb_req_t  pix_req,
    input  conceal_pkg::pix_wb_rsp_t  pix_rsp,
    output conceal_pkg::flag_wb_req_t flag_req,
    input  conceal_pkg::flag_wb_rsp_t flag_rsp
);

    conceal_pkg::conceal_job_t job;
    conceal_pkg::neighbours_t  nbrs;
    conceal_pkg::edge_flags_t  edges;
    logic                      job_valid;
    logic                      job_done;
    logic                      sum_start;
    logic [`PIXEL_W-1:0]       average;
    logic                      average_valid;

    frame_sequencer i_frame_sequencer (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .size      (size),
        .done      (done),
        .flag_req  (flag_req),
        .flag_rsp  (flag_rsp),
        .job       (job),
        .job_valid (job_valid),
        .job_done  (job_done)
    );

    pixel_port i_pixel_port (
        .clock         (clock),
        .reset         (reset),
        .job           (job),
        .job_valid     (job_valid),
        .job_done      (job_done),
        .pix_req       (pix_req),
        .pix_rsp       (pix_rsp),
        .nbrs          (nbrs),
        .edges         (edges),
        .sum_start     (sum_start),
        .average       (average),
        .average_valid (average_valid)
    );

    neighbour_average i_neighbour_average (
        .clock         (clock),
        .reset         (reset),
        .nbrs          (nbrs),
        .edges         (edges),
        .sum_start     (sum_start),
        .average       (average),
        .average_valid (average_valid)
    );

endmodule

// File: test/concealment_checker.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module concealment_checker (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      done,
    input  conceal_pkg::pix_wb_req_t  pix_req,
    input  conceal_pkg::pix_wb_rsp_t  pix_rsp,
    input  conceal_pkg::flag_wb_req_t flag_req,
    input  conceal_pkg::flag_wb_rsp_t flag_rsp
);

    localparam int FRAME_PIX = `FRAME_WIDTH * `FRAME_LINES;

    logic [`PIXEL_W-1:0]      mirror [0:FRAME_PIX-1];
    bit                       written [0:FRAME_PIX-1];
    conceal_pkg::pix_wb_req_t held;
    bit                       pending;
    int                       reads [$];
    int errors = 0;
    int test_errors;
    int tests_run = 0;
    int test_num;
    int pix_per_packet;
    int expected_writes;
    int writes;
    int flag_reads;
    int done_count;
    int stall;

    task automatic record_failure(string msg);
        $display("%s", msg);
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic report_mismatch(string msg);
        $display("ERR %0t: %s", $time, msg);
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    function automatic int px(int line, int col);
        return mirror[line * `FRAME_WIDTH + col];
    endfunction

    // Edge pixels double the nearest present neighbours
    function automatic int expected_average(int adr);
        int l;
        int c;
        int sum;
        l = adr / `FRAME_WIDTH;
        c = adr % `FRAME_WIDTH;
        case ({l == 0, l == `FRAME_LINES - 1, c == 0, c == `FRAME_WIDTH - 1})
            4'b1010: sum = 3 * px(l, c + 1) + 3 * px(l + 1, c) + 2 * px(l + 1, c + 1);
            4'b1001: sum = 3 * px(l, c - 1) + 3 * px(l + 1, c) + 2 * px(l + 1, c - 1);
            4'b0110: sum = 3 * px(l - 1, c) + 3 * px(l, c + 1) + 2 * px(l - 1, c + 1);
            4'b0101: sum = 3 * px(l, c - 1) + 3 * px(l - 1, c) + 2 * px(l - 1, c - 1);
            4'b1000: sum = 2 * px(l, c - 1) + px(l + 1, c - 1) + 2 * px(l + 1, c)
                         + px(l + 1, c + 1) + 2 * px(l, c + 1);
            4'b0100: sum = 2 * px(l, c - 1) + px(l - 1, c - 1) + 2 * px(l - 1, c)
                         + px(l - 1, c + 1) + 2 * px(l, c + 1);
            4'b0010: sum = 2 * px(l - 1, c) + px(l - 1, c + 1) + 2 * px(l, c + 1)
                         + px(l + 1, c + 1) + 2 * px(l + 1, c);
            4'b0001: sum = 2 * px(l - 1, c) + px(l - 1, c - 1) + 2 * px(l, c - 1)
                         + px(l + 1, c - 1) + 2 * px(l + 1, c);
            default: begin
                sum = 0;
                for (int dl = -1; dl <= 1; dl++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dl != 0 || dc != 0) sum = sum + px(l + dl, c + dc);
                    end
                end
            end
        endcase
        return sum / 8;
    endfunction

    // Reads since the last write must be the in-frame neighbours, nw first and se last
    task automatic compare_reads(int adr);
        int l;
        int c;
        int k;
        bit ok;
        l  = adr / `FRAME_WIDTH;
        c  = adr % `FRAME_WIDTH;
        k  = 0;
        ok = 1'b1;
        for (int dl = -1; dl <= 1; dl++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                if ((dl != 0 || dc != 0) && l + dl >= 0 && l + dl < `FRAME_LINES
                    && c + dc >= 0 && c + dc < `FRAME_WIDTH) begin
                    if (k >= reads.size()
                        || reads[k] != (l + dl) * `FRAME_WIDTH + c + dc) begin
                        ok = 1'b0;
                    end
                    k = k + 1;
                end
            end
        end
        if (!ok || k != reads.size()) begin
            record_failure($sformatf("Neighbour reads for pixel %0d are not the in-frame set",
                                     adr));
        end
        reads.delete();
    endtask

    task automatic check_write(int adr, int dat);
        int line;
        int packet;
        int exp;
        line   = adr / `FRAME_WIDTH;
        packet = (adr % `FRAME_WIDTH) / pix_per_packet;
        if (!tb_concealment.flag_mem[line][`FLAG_W - 1 - packet]) begin
            record_failure($sformatf("Write to pixel %0d outside a flagged packet", adr));
        end
        if (written[adr]) begin
            record_failure($sformatf("Pixel %0d was written twice", adr));
        end
        compare_reads(adr);
        written[adr] = 1'b1;
        writes = writes + 1;
        exp = expected_average(adr);
        if (dat != exp) begin
            report_mismatch($sformatf("test %0d pixel %0d wrote %0h, expected %0h",
                                      test_num, adr, dat, exp));
        end
        mirror[adr] = dat;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            if (done) done_count = done_count + 1;
            if (flag_req.cyc && flag_rsp.ack) begin
                if (flag_req.adr != flag_reads) begin
                    report_mismatch($sformatf("flag read at line %0d, expected line %0d",
                                              flag_req.adr, flag_reads));
                end
                flag_reads = flag_reads + 1;
            end
            if (pix_req.cyc && pix_req.stb) begin
                if (pending && pix_req !== held) begin
                    record_failure("Pixel request changed before its ack");
                end
                if (pix_req.adr >= FRAME_PIX) begin
                    record_failure($sformatf("Pixel access at %0d outside the frame",
                                             pix_req.adr));
                end else if (pix_rsp.ack) begin
                    pending = 1'b0;
                    stall   = 0;
                    if (pix_req.we) begin
                        check_write(pix_req.adr, pix_req.dat);
                    end else begin
                        reads.push_back(pix_req.adr);
                    end
                end else begin
                    pending = 1'b1;
                    held    = pix_req;
                    stall   = stall + 1;
                    if (stall == 16) record_failure("Pixel access never acknowledged");
                end
            end
        end
    end

    task automatic begin_test(int num, int code, int expected);
        for (int i = 0; i < FRAME_PIX; i++) begin
            mirror[i]  = tb_concealment.pix_mem[i];
            written[i] = 1'b0;
        end
        pix_per_packet  = (code == 1) ? 32 : (code == 2) ? 64 : 16;
        test_num        = num;
        expected_writes = expected;
        writes          = 0;
        flag_reads      = 0;
        done_count      = 0;
        test_errors     = 0;
        pending         = 1'b0;
        stall           = 0;
        reads.delete();
    endtask

    task automatic end_test();
        if (writes != expected_writes) begin
            report_mismatch($sformatf("test %0d expected %0d writes, saw %0d",
                                      test_num, expected_writes, writes));
        end
        if (flag_reads != `FRAME_LINES) begin
            report_mismatch($sformatf("test %0d expected %0d flag reads, saw %0d",
                                      test_num, `FRAME_LINES, flag_reads));
        end
        if (done_count != 1) record_failure("Done did not pulse exactly once");
        tests_run = tests_run + 1;
        $display("test %0d: %0d writes, %0d flag reads, %0d errors",
                 test_num, writes, flag_reads, test_errors);
    endtask

    task automatic check_idle();
        test_errors = 0;
        if (done || pix_req.cyc || pix_req.stb || pix_req.we || flag_req.cyc || flag_req.stb) begin
            record_failure("Outputs not idle after reset");
        end
    endtask

    task automatic report_counts();
        $display("tests run %0d, failed checks %0d", tests_run, errors);
    endtask

endmodule

// File: test/tb_concealment.sv
`timescale 1ns/1ps
`include "conceal_cfg.svh"

module tb_concealment;

    localparam int TIMEOUT = 200000;

    logic                       clock = 1'b0;
    logic                       reset;
    logic                       start;
    conceal_pkg::packet_size_e  size;
    logic                       done;
    conceal_pkg::pix_wb_req_t   pix_req;
    conceal_pkg::pix_wb_rsp_t   pix_rsp;
    conceal_pkg::flag_wb_req_t  flag_req;
    conceal_pkg::flag_wb_rsp_t  flag_rsp;
    logic [`PIXEL_W-1:0]        pix_mem [0:`FRAME_WIDTH*`FRAME_LINES-1];
    logic [`FLAG_W-1:0]         flag_mem [0:`FRAME_LINES-1];
    logic [15:0]                vec [0:255];
    logic [31:0]                lfsr;
    logic [1:0]                 pix_wait;
    logic [1:0]                 flag_wait;
    int                         pos;
    bit                         timed_out;

    always #20 clock = ~clock;

    concealment_top i_concealment_top (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .size     (size),
        .done     (done),
        .pix_req  (pix_req),
        .pix_rsp  (pix_rsp),
        .flag_req (flag_req),
        .flag_rsp (flag_rsp)
    );

    concealment_checker i_checker (
        .clock    (clock),
        .reset    (reset),
        .done     (done),
        .pix_req  (pix_req),
        .pix_rsp  (pix_rsp),
        .flag_req (flag_req),
        .flag_rsp (flag_rsp)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [7:0] take_bits(int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[6:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Memory models, ack after a random extra delay of 0 to 3 cycles
    always @(posedge clock) begin
        if (pix_rsp.ack) begin
            pix_rsp.ack <= 1'b0;
        end else if (pix_req.cyc && pix_req.stb) begin
            if (pix_wait == 2'd0) begin
                pix_rsp.ack <= 1'b1;
                pix_rsp.dat <= pix_mem[pix_req.adr];
                if (pix_req.we) begin
                    pix_mem[pix_req.adr] <= pix_req.dat;
                end
                pix_wait <= 2'(take_bits(2));
            end else begin
                pix_wait <= pix_wait - 2'd1;
            end
        end
        if (flag_rsp.ack) begin
            flag_rsp.ack <= 1'b0;
        end else if (flag_req.cyc && flag_req.stb) begin
            if (flag_wait == 2'd0) begin
                flag_rsp.ack <= 1'b1;
                flag_rsp.dat <= flag_mem[flag_req.adr];
                flag_wait    <= 2'(take_bits(2));
            end else begin
                flag_wait <= flag_wait - 2'd1;
            end
        end
    end

    task automatic run_test();
        int  num;
        int  code;
        int  lines;
        int  expected;
        int  cycles;
        bit  seen;
        num      = vec[pos];
        code     = vec[pos + 1];
        lines    = vec[pos + 2];
        expected = vec[pos + 3];
        pos      = pos + 4;
        for (int i = 0; i < `FRAME_LINES; i++) begin
            flag_mem[i] = '0;
        end
        for (int i = 0; i < lines; i++) begin
            flag_mem[vec[pos]] = vec[pos + 1];
            pos = pos + 2;
        end
        i_checker.begin_test(num, code, expected);
        @(posedge clock);
        start <= 1'b1;
        size  <= conceal_pkg::packet_size_e'(code);
        cycles = 0;
        seen   = 1'b0;
        // A stray start while busy must be ignored
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clock);
            start <= (cycles == 50);
            @(negedge clock);
            seen   = done;
            cycles = cycles + 1;
        end
        if (!seen) begin
            $display("Timed out waiting for done in test %0d", num);
            timed_out = 1'b1;
        end else begin
            repeat (20) @(posedge clock);
            i_checker.end_test();
        end
    endtask

    initial begin
        reset     = 1'b0;
        start     = 1'b0;
        size      = conceal_pkg::SIZE_16;
        pix_rsp   = '0;
        flag_rsp  = '0;
        pix_wait  = 2'd0;
        flag_wait = 2'd0;
        lfsr      = 32'hfe7ac87c;
        timed_out = 1'b0;
        for (int i = 0; i < `FRAME_WIDTH * `FRAME_LINES; i++) begin
            pix_mem[i] = take_bits(8);
        end
        $readmemh("test/concealment_vectors.txt", vec);
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        i_checker.check_idle();
        pos = 0;
        while (vec[pos] != 16'd0 && !timed_out) begin
            run_test();
        end
        i_checker.report_counts();
        if (timed_out || i_checker.errors != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+src
src/conceal_pkg.sv
src/frame_sequencer.sv
src/pixel_port.sv
src/neighbour_average.sv
src/concealment_top.sv
test/concealment_checker.sv
test/tb_concealment.sv

// File: test/concealment_vectors.txt
// Per test: number, size code, flagged line count, expected writes, then line and mask pairs
// A test number of zero ends the list
0001 0000 0000 0000
0002 0000 0001 0010 0050 0100
0003 0000 0003 0060 0000 8001 00ef 8001 0030 8001
0004 0001 0001 0040 0010 8100
0005 0002 0002 0080 0077 4000 00ef 1000
0000
